// File: build.sh
#!/bin/sh
# Compile and run the rv32i_trio testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_rv32i_trio
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f rv32i_trio.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: dmem_arbiter.sv
`timescale 1ns/1ps

module dmem_arbiter import trio_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic      [NUM_LANES-1:0] i_req_valid,
    input  dmem_req_t [NUM_LANES-1:0] i_req,
    input  logic                      i_dmem_rvalid,
    input  word_t                     i_dmem_rdata,
    output logic      [NUM_LANES-1:0] o_grant,
    output word_t                     o_rdata,
    output logic      [NUM_LANES-1:0] o_rvalid,
    output logic                      o_dmem_valid,
    output dmem_req_t                 o_dmem_req,
    output logic      [1:0]           o_stall_count
);

    logic                 load_busy;
    logic [NUM_LANES-1:0] load_owner;

    // Lane 0 highest, port closed while a load is in flight
    always_comb begin
        o_grant    = '0;
        o_dmem_req = '0;
        if (!load_busy) begin
            for (int k = NUM_LANES-1; k >= 0; k--) begin
                if (i_req_valid[k]) begin
                    o_grant    = '0;
                    o_grant[k] = 1'b1;
                    o_dmem_req = i_req[k];
                end
            end
        end
    end

    assign o_dmem_valid  = |o_grant;
    assign o_stall_count = 2'($countones(i_req_valid)) - 2'($countones(o_grant));
    assign o_rdata       = i_dmem_rdata;
    assign o_rvalid      = (load_busy && i_dmem_rvalid) ? load_owner : '0;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            load_busy  <= 1'b0;
            load_owner <= '0;
        end else if (load_busy) begin
            if (i_dmem_rvalid) begin
                load_busy <= 1'b0;
            end
        end else if (o_dmem_valid && !o_dmem_req.we) begin
            load_busy  <= 1'b1;
            load_owner <= o_grant;
        end
    end

endmodule

// File: exec_lane.sv
`timescale 1ns/1ps

module exec_lane import trio_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         i_valid,
    input  fetch_entry_t i_entry,
    input  word_t        i_rs1_data,
    input  word_t        i_rs2_data,
    input  logic         i_grant,
    input  word_t        i_rdata,
    input  logic         i_rvalid,
    output reg_idx_t     o_rs1_addr,
    output reg_idx_t     o_rs2_addr,
    output logic         o_busy,
    output logic         o_we,
    output reg_idx_t     o_wr_addr,
    output word_t        o_wr_data,
    output logic         o_mem_valid,
    output dmem_req_t    o_mem_req,
    output logic         o_retire
);

    opcode_t    opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      operand_b;
    word_t      alu_result;
    logic       alu_hit;
    logic       is_load;
    logic       is_mem_new;
    dmem_req_t  new_req;
    logic       mem_done;
    logic       pend;
    logic       wait_data;
    dmem_req_t  pend_req;
    reg_idx_t   pend_rd;

    // ============================================================
    // Decode and ALU
    // ============================================================
    assign opcode     = opcode_t'(i_entry.instr[6:0]);
    assign funct3     = i_entry.instr[14:12];
    assign rd         = i_entry.instr[11:7];
    assign o_rs1_addr = i_entry.instr[19:15];
    assign o_rs2_addr = i_entry.instr[24:20];

    assign imm_i     = {{20{i_entry.instr[31]}}, i_entry.instr[31:20]};
    assign imm_s     = {{20{i_entry.instr[31]}}, i_entry.instr[31:25], i_entry.instr[11:7]};
    assign operand_b = (opcode == OPC_OP) ? i_rs2_data : imm_i;

    always_comb begin
        alu_hit    = (opcode == OPC_OP) || (opcode == OPC_OP_IMM);
        alu_result = '0;
        case (funct3)
            3'b000: begin
                if (opcode == OPC_OP && i_entry.instr[30]) begin
                    alu_result = i_rs1_data - operand_b;
                end else begin
                    alu_result = i_rs1_data + operand_b;
                end
            end
            // SLT only, SLTI is not supported
            3'b010: begin
                alu_result = {31'b0, $signed(i_rs1_data) < $signed(operand_b)};
                alu_hit    = (opcode == OPC_OP);
            end
            3'b100:  alu_result = i_rs1_data ^ operand_b;
            3'b110:  alu_result = i_rs1_data | operand_b;
            3'b111:  alu_result = i_rs1_data & operand_b;
            default: alu_hit = 1'b0;
        endcase
        if (opcode == OPC_LUI) begin
            alu_hit    = 1'b1;
            alu_result = {i_entry.instr[31:12], 12'h000};
        end
    end

    // ============================================================
    // Memory access
    // ============================================================
    assign is_load       = (opcode == OPC_LOAD);
    assign is_mem_new    = i_valid && (is_load || opcode == OPC_STORE);
    assign new_req.addr  = i_rs1_data + (is_load ? imm_i : imm_s);
    assign new_req.wdata = i_rs2_data;
    assign new_req.we    = !is_load;

    assign o_mem_valid = is_mem_new || (pend && !wait_data);
    assign o_mem_req   = pend ? pend_req : new_req;
    // Store ends on grant, load on its data return
    assign mem_done    = (o_mem_valid && i_grant && o_mem_req.we) || (wait_data && i_rvalid);
    assign o_busy      = (is_mem_new || pend) && !mem_done;
    assign o_retire    = (i_valid && !is_mem_new) || mem_done;

    assign o_we      = (i_valid && alu_hit) || (wait_data && i_rvalid);
    assign o_wr_addr = wait_data ? pend_rd : rd;
    assign o_wr_data = wait_data ? i_rdata : alu_result;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pend      <= 1'b0;
            wait_data <= 1'b0;
        end else if (mem_done) begin
            pend      <= 1'b0;
            wait_data <= 1'b0;
        end else if (o_mem_valid && i_grant) begin
            pend      <= 1'b1;
            wait_data <= 1'b1;
        end else if (is_mem_new) begin
            pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (is_mem_new) begin
            pend_req <= new_req;
            pend_rd  <= rd;
        end
    end

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import trio_pkg::*; #(
    parameter int    BUFFER_DEPTH = 8,
    parameter word_t RESET_PC     = '0
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         i_fetch_valid,
    input  word_t        [NUM_LANES-1:0] i_fetch_words,
    input  logic         [1:0]           i_pop,
    output logic                         o_fetch_req,
    output word_t                        o_fetch_addr,
    output fetch_entry_t [NUM_LANES-1:0] o_head,
    output logic         [1:0]           o_count,
    output logic                         o_full
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH);

    fetch_entry_t     buffer_mem [BUFFER_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill;
    logic [PTR_W:0]   fill_next;
    word_t            fetch_pc;
    logic             req_q;

    // Occupancy after this edge
    assign fill_next = fill + (i_fetch_valid ? (PTR_W+1)'(NUM_LANES) : '0)
                     - (PTR_W+1)'(i_pop);

    assign o_full       = (fill > (PTR_W+1)'(BUFFER_DEPTH - NUM_LANES));
    assign o_fetch_req  = req_q;
    assign o_fetch_addr = fetch_pc;
    assign o_count      = (fill >= (PTR_W+1)'(NUM_LANES)) ? 2'(NUM_LANES) : fill[1:0];

    // Head window, wraps around the ring
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            o_head[k] = buffer_mem[rd_ptr + PTR_W'(k)];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            fetch_pc <= RESET_PC;
            req_q    <= 1'b0;
        end else begin
            fill   <= fill_next;
            rd_ptr <= rd_ptr + PTR_W'(i_pop);
            // Answer lands next cycle, so never two strobes back to back
            req_q  <= !req_q && (fill_next <= (PTR_W+1)'(BUFFER_DEPTH - NUM_LANES));
            if (i_fetch_valid) begin
                wr_ptr   <= wr_ptr + PTR_W'(NUM_LANES);
                fetch_pc <= fetch_pc + word_t'(4 * NUM_LANES);
            end
        end
    end

    // Returned words tagged with their pc
    always_ff @(posedge clk) begin
        if (i_fetch_valid) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                buffer_mem[wr_ptr + PTR_W'(k)] <= '{pc:    fetch_pc + word_t'(4 * k),
                                                    instr: i_fetch_words[k]};
            end
        end
    end

endmodule

// File: issue_unit.sv
`timescale 1ns/1ps

module issue_unit import trio_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  fetch_entry_t [NUM_LANES-1:0] i_head,
    input  logic         [1:0]           i_count,
    input  logic         [NUM_LANES-1:0] i_lane_busy,
    output logic         [1:0]           o_pop,
    output logic         [NUM_LANES-1:0] o_issue_valid,
    output fetch_entry_t [NUM_LANES-1:0] o_issue_entry
);

    opcode_t  [NUM_LANES-1:0] opc;
    reg_idx_t [NUM_LANES-1:0] rd;
    reg_idx_t [NUM_LANES-1:0] rs1;
    reg_idx_t [NUM_LANES-1:0] rs2;
    logic     [NUM_LANES-1:0] writes_rd;
    logic     [NUM_LANES-1:0] reads_rs1;
    logic     [NUM_LANES-1:0] reads_rs2;
    logic     [NUM_LANES-1:0] is_mem;
    logic     [NUM_LANES-1:0] take;
    logic                     hold;

    // Register usage per head entry, x0 writes count as none
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            opc[k]       = opcode_t'(i_head[k].instr[6:0]);
            rd[k]        = i_head[k].instr[11:7];
            rs1[k]       = i_head[k].instr[19:15];
            rs2[k]       = i_head[k].instr[24:20];
            is_mem[k]    = (opc[k] == OPC_LOAD) || (opc[k] == OPC_STORE);
            writes_rd[k] = ((opc[k] == OPC_OP) || (opc[k] == OPC_OP_IMM) ||
                            (opc[k] == OPC_LUI) || (opc[k] == OPC_LOAD)) && (rd[k] != '0);
            reads_rs1[k] = (opc[k] == OPC_OP) || (opc[k] == OPC_OP_IMM) || is_mem[k];
            reads_rs2[k] = (opc[k] == OPC_OP) || (opc[k] == OPC_STORE);
        end
    end

    // Group grows in order and stops at the first conflict
    always_comb begin
        take[0] = (i_count != 2'd0);
        for (int j = 1; j < NUM_LANES; j++) begin
            take[j] = take[j-1] && (i_count > 2'(j));
            for (int i = 0; i < j; i++) begin
                if (writes_rd[i] && ((reads_rs1[j] && rs1[j] == rd[i]) ||
                                     (reads_rs2[j] && rs2[j] == rd[i]) ||
                                     (writes_rd[j] && rd[j] == rd[i]))) begin
                    take[j] = 1'b0;
                end
                if (is_mem[i] && is_mem[j]) begin
                    take[j] = 1'b0;
                end
            end
        end
    end

    assign hold  = |i_lane_busy;
    assign o_pop = hold ? 2'd0 : 2'($countones(take));

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            o_issue_valid <= '0;
        end else begin
            o_issue_valid <= hold ? '0 : take;
        end
    end

    always_ff @(posedge clk) begin
        o_issue_entry <= i_head;
    end

endmodule

// File: perf_counters.sv
`timescale 1ns/1ps

module perf_counters import trio_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_LANES-1:0] i_retire,
    input  logic [1:0]           i_stall_count,
    input  logic                 i_buffer_full,
    output perf_t                o_perf
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            o_perf <= '0;
        end else begin
            o_perf.cycles      <= o_perf.cycles + 1'b1;
            // Up to one retire per lane each cycle
            o_perf.retired     <= o_perf.retired + word_t'($countones(i_retire));
            o_perf.arb_stalls  <= o_perf.arb_stalls + word_t'(i_stall_count);
            o_perf.buffer_full <= o_perf.buffer_full + word_t'(i_buffer_full);
        end
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file import trio_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  reg_idx_t [2*NUM_LANES-1:0]   i_rs_addr,
    input  logic     [NUM_LANES-1:0]     i_we,
    input  reg_idx_t [NUM_LANES-1:0]     i_wr_addr,
    input  word_t    [NUM_LANES-1:0]     i_wr_data,
    output word_t    [2*NUM_LANES-1:0]   o_rs_data
);

    word_t regs [32];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Higher lane wins on a shared index
            for (int k = 0; k < NUM_LANES; k++) begin
                if (i_we[k] && i_wr_addr[k] != '0) begin
                    regs[i_wr_addr[k]] <= i_wr_data[k];
                end
            end
        end
    end

    // Two ports per lane, rs1 then rs2
    always_comb begin
        for (int p = 0; p < 2*NUM_LANES; p++) begin
            o_rs_data[p] = (i_rs_addr[p] == '0) ? '0 : regs[i_rs_addr[p]];
        end
    end

endmodule

// File: rv32i_trio.f
trio_pkg.sv
fetch_unit.sv
issue_unit.sv
reg_file.sv
exec_lane.sv
dmem_arbiter.sv
perf_counters.sv
rv32i_trio_core.sv
tb_rv32i_trio.sv

// File: rv32i_trio_core.sv
`timescale 1ns/1ps

module rv32i_trio_core import trio_pkg::*; #(
    parameter int    BUFFER_DEPTH = 8,
    parameter word_t RESET_PC     = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  o_fetch_req,
    output word_t                 o_fetch_addr,
    input  logic                  i_fetch_valid,
    input  word_t [NUM_LANES-1:0] i_fetch_words,
    output logic                  o_dmem_valid,
    output dmem_req_t             o_dmem_req,
    input  logic                  i_dmem_rvalid,
    input  word_t                 i_dmem_rdata,
    output perf_t                 o_perf
);

    fetch_entry_t [NUM_LANES-1:0]   head;
    logic         [1:0]             head_count;
    logic         [1:0]             pop;
    logic                           buffer_full;
    logic         [NUM_LANES-1:0]   issue_valid;
    fetch_entry_t [NUM_LANES-1:0]   issue_entry;
    logic         [NUM_LANES-1:0]   lane_busy;
    reg_idx_t     [2*NUM_LANES-1:0] rs_addr;
    word_t        [2*NUM_LANES-1:0] rs_data;
    logic         [NUM_LANES-1:0]   we;
    reg_idx_t     [NUM_LANES-1:0]   wr_addr;
    word_t        [NUM_LANES-1:0]   wr_data;
    logic         [NUM_LANES-1:0]   mem_valid;
    dmem_req_t    [NUM_LANES-1:0]   mem_req;
    logic         [NUM_LANES-1:0]   grant;
    word_t                          lane_rdata;
    logic         [NUM_LANES-1:0]   lane_rvalid;
    logic         [NUM_LANES-1:0]   retire;
    logic         [1:0]             stall_count;

    // ============================================================
    // Front end
    // ============================================================
    fetch_unit #(
        .BUFFER_DEPTH (BUFFER_DEPTH),
        .RESET_PC     (RESET_PC)
    ) u_fetch (
        .clk           (clk),
        .reset         (reset),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch_words (i_fetch_words),
        .i_pop         (pop),
        .o_fetch_req   (o_fetch_req),
        .o_fetch_addr  (o_fetch_addr),
        .o_head        (head),
        .o_count       (head_count),
        .o_full        (buffer_full)
    );

    issue_unit u_issue (
        .clk           (clk),
        .reset         (reset),
        .i_head        (head),
        .i_count       (head_count),
        .i_lane_busy   (lane_busy),
        .o_pop         (pop),
        .o_issue_valid (issue_valid),
        .o_issue_entry (issue_entry)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .reset     (reset),
        .i_rs_addr (rs_addr),
        .i_we      (we),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .o_rs_data (rs_data)
    );

    // ============================================================
    // Execution lanes
    // ============================================================
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        exec_lane u_lane (
            .clk         (clk),
            .reset       (reset),
            .i_valid     (issue_valid[g]),
            .i_entry     (issue_entry[g]),
            .i_rs1_data  (rs_data[2*g]),
            .i_rs2_data  (rs_data[2*g+1]),
            .i_grant     (grant[g]),
            .i_rdata     (lane_rdata),
            .i_rvalid    (lane_rvalid[g]),
            .o_rs1_addr  (rs_addr[2*g]),
            .o_rs2_addr  (rs_addr[2*g+1]),
            .o_busy      (lane_busy[g]),
            .o_we        (we[g]),
            .o_wr_addr   (wr_addr[g]),
            .o_wr_data   (wr_data[g]),
            .o_mem_valid (mem_valid[g]),
            .o_mem_req   (mem_req[g]),
            .o_retire    (retire[g])
        );
    end

    dmem_arbiter u_arbiter (
        .clk           (clk),
        .reset         (reset),
        .i_req_valid   (mem_valid),
        .i_req         (mem_req),
        .i_dmem_rvalid (i_dmem_rvalid),
        .i_dmem_rdata  (i_dmem_rdata),
        .o_grant       (grant),
        .o_rdata       (lane_rdata),
        .o_rvalid      (lane_rvalid),
        .o_dmem_valid  (o_dmem_valid),
        .o_dmem_req    (o_dmem_req),
        .o_stall_count (stall_count)
    );

    perf_counters u_perf (
        .clk           (clk),
        .reset         (reset),
        .i_retire      (retire),
        .i_stall_count (stall_count),
        .i_buffer_full (buffer_full),
        .o_perf        (o_perf)
    );

endmodule

// File: tb_rv32i_trio.sv
`timescale 1ns/1ps

module tb_rv32i_trio import trio_pkg::*; ();

    localparam int    ROM_WORDS = 64;
    localparam int    RAM_WORDS = 256;
    localparam int    TIMEOUT   = 2000;
    localparam word_t NOP       = 32'h0000_0013;

    logic                  clk;
    logic                  reset;
    logic                  o_fetch_req;
    word_t                 o_fetch_addr;
    logic                  i_fetch_valid;
    word_t [NUM_LANES-1:0] i_fetch_words;
    logic                  o_dmem_valid;
    dmem_req_t             o_dmem_req;
    logic                  i_dmem_rvalid;
    word_t                 i_dmem_rdata;
    perf_t                 o_perf;

    word_t  rom [ROM_WORDS];
    word_t  ram [RAM_WORDS];
    word_t  ref_ram [RAM_WORDS];
    word_t  ref_regs [32];
    word_t  exp_addr [$];
    word_t  exp_data [$];
    int     prog_len;
    int     store_count;
    int     mismatches;
    int     failures;
    integer seed;
    logic   fetch_pend;
    word_t  fetch_addr_q;
    logic   load_pend;
    word_t  load_addr_q;
    int     load_lat;
    logic   counting;
    word_t  prev_cycles;
    word_t  prev_full;

    rv32i_trio_core #(
        .BUFFER_DEPTH (8),
        .RESET_PC     (32'h0000_0000)
    ) i_rv32i_trio_core (
        .clk           (clk),
        .reset         (reset),
        .o_fetch_req   (o_fetch_req),
        .o_fetch_addr  (o_fetch_addr),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch_words (i_fetch_words),
        .o_dmem_valid  (o_dmem_valid),
        .o_dmem_req    (o_dmem_req),
        .i_dmem_rvalid (i_dmem_rvalid),
        .i_dmem_rdata  (i_dmem_rdata),
        .o_perf        (o_perf)
    );

    always #5 clk = ~clk;

    // ============================================================
    // Instruction encoding and program
    // ============================================================
    function automatic word_t r_type(input logic [6:0] funct7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] funct3,
                                     input reg_idx_t rd);
        return {funct7, rs2, rs1, funct3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] funct3, input reg_idx_t rd,
                                     input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic word_t sw_op(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t lui_op(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    task automatic append(input word_t instr);
        rom[prog_len] = instr;
        prog_len++;
    endtask

    task automatic build_program;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = NOP;
        end
        // Independent ALU work, three per group
        append(i_type(12'd100, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        append(i_type(12'hff9, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
        append(lui_op(20'h12345, 5'd3));
        append(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
        append(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd5));
        append(r_type(7'h00, 5'd2, 5'd3, 3'b111, 5'd6));
        append(r_type(7'h00, 5'd2, 5'd3, 3'b110, 5'd7));
        append(r_type(7'h00, 5'd3, 5'd1, 3'b100, 5'd8));
        append(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd9));
        append(i_type(12'h055, 5'd1, 3'b100, 5'd10, OPC_OP_IMM));
        append(i_type(12'h0f0, 5'd2, 3'b110, 5'd11, OPC_OP_IMM));
        append(i_type(12'h7f3, 5'd1, 3'b111, 5'd12, OPC_OP_IMM));
        for (int r = 1; r <= 12; r++) begin
            append(sw_op(12'(256 + 4 * r), reg_idx_t'(r), 5'd0));
        end
        // Dependent chains inside one fetch group
        append(i_type(12'd21, 5'd0, 3'b000, 5'd13, OPC_OP_IMM));
        append(r_type(7'h00, 5'd13, 5'd13, 3'b000, 5'd14));
        append(r_type(7'h00, 5'd1, 5'd14, 3'b100, 5'd15));
        append(i_type(12'd1, 5'd0, 3'b000, 5'd16, OPC_OP_IMM));
        append(i_type(12'd2, 5'd16, 3'b000, 5'd16, OPC_OP_IMM));
        append(i_type(12'd40, 5'd16, 3'b000, 5'd16, OPC_OP_IMM));
        append(sw_op(12'h140, 5'd14, 5'd0));
        append(sw_op(12'h144, 5'd15, 5'd0));
        append(sw_op(12'h148, 5'd16, 5'd0));
        // Loads feeding ALU work and stores
        append(i_type(12'h104, 5'd0, 3'b010, 5'd17, OPC_LOAD));
        append(i_type(12'd1, 5'd17, 3'b000, 5'd18, OPC_OP_IMM));
        append(sw_op(12'h200, 5'd18, 5'd0));
        append(i_type(12'h110, 5'd0, 3'b010, 5'd19, OPC_LOAD));
        append(r_type(7'h00, 5'd17, 5'd19, 3'b000, 5'd20));
        append(sw_op(12'h204, 5'd20, 5'd0));
        append(i_type(12'h300, 5'd0, 3'b010, 5'd21, OPC_LOAD));
        append(sw_op(12'h208, 5'd21, 5'd0));
        // Writes to x0 must not stick
        append(i_type(12'd55, 5'd0, 3'b000, 5'd0, OPC_OP_IMM));
        append(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        append(sw_op(12'h20c, 5'd0, 5'd0));
        append(lui_op(20'hfffff, 5'd0));
        append(sw_op(12'h210, 5'd0, 5'd0));
        // Stores in consecutive groups, with a base register
        append(sw_op(12'h004, 5'd7, 5'd1));
        append(sw_op(12'hfe0, 5'd8, 5'd1));
        append(sw_op(12'h24c, 5'd9, 5'd0));
    endtask

    // Sequential ISA model, builds the expected store list
    task automatic run_reference;
        word_t ins;
        word_t a;
        word_t b;
        word_t imm;
        word_t res;
        logic  wr;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int n = 0; n < prog_len; n++) begin
            ins = rom[n];
            a   = ref_regs[ins[19:15]];
            b   = ref_regs[ins[24:20]];
            imm = {{20{ins[31]}}, ins[31:20]};
            wr  = 1'b1;
            res = '0;
            case (ins[6:0])
                OPC_OP: begin
                    case (ins[14:12])
                        3'b000:  res = ins[30] ? a - b : a + b;
                        3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        3'b111:  res = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                OPC_OP_IMM: begin
                    case (ins[14:12])
                        3'b000:  res = a + imm;
                        3'b100:  res = a ^ imm;
                        3'b110:  res = a | imm;
                        3'b111:  res = a & imm;
                        default: wr = 1'b0;
                    endcase
                end
                OPC_LUI:  res = {ins[31:12], 12'h000};
                OPC_LOAD: res = ref_ram[(a + imm) >> 2];
                OPC_STORE: begin
                    wr  = 1'b0;
                    imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    ref_ram[(a + imm) >> 2] = b;
                    exp_addr.push_back(a + imm);
                    exp_data.push_back(b);
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                ref_regs[ins[11:7]] = res;
            end
        end
    endtask

    // ============================================================
    // Memory models
    // ============================================================
    function automatic word_t rom_word(input word_t addr);
        if (addr < word_t'(4 * ROM_WORDS)) begin
            return rom[addr[7:2]];
        end
        return NOP;
    endfunction

    task automatic check_store(input word_t addr, input word_t data);
        if (store_count >= exp_addr.size()) begin
            failures++;
            $display("unexpected extra store of %h to address %h", data, addr);
        end else begin
            assert (addr == exp_addr[store_count]) else begin
                mismatches++;
                $display("mismatch o_dmem_req.addr: got %h expected %h",
                         addr, exp_addr[store_count]);
            end
            assert (data == exp_data[store_count]) else begin
                mismatches++;
                $display("mismatch o_dmem_req.wdata: got %h expected %h",
                         data, exp_data[store_count]);
            end
        end
        store_count++;
    endtask

    task automatic check_perf;
        if (!counting) begin
            assert (o_perf == '0) else begin
                mismatches++;
                $display("mismatch o_perf: got %h expected %h", o_perf, 128'h0);
            end
        end else begin
            assert (o_perf.cycles == prev_cycles + 32'd1) else begin
                mismatches++;
                $display("mismatch o_perf.cycles: got %h expected %h",
                         o_perf.cycles, prev_cycles + 32'd1);
            end
            assert (o_perf.buffer_full - prev_full <= 32'd1) else begin
                failures++;
                $display("buffer_full moved from %0d to %0d in one cycle",
                         prev_full, o_perf.buffer_full);
            end
        end
        assert (longint'(o_perf.retired) <= 3 * longint'(o_perf.cycles)) else begin
            failures++;
            $display("retired count %0d is more than three per cycle over %0d cycles",
                     o_perf.retired, o_perf.cycles);
        end
        // One memory op per group and issue waits on busy lanes, so no lane is refused
        assert (o_perf.arb_stalls == '0) else begin
            mismatches++;
            $display("mismatch o_perf.arb_stalls: got %h expected %h",
                     o_perf.arb_stalls, 32'h0);
        end
        counting    = 1'b1;
        prev_cycles = o_perf.cycles;
        prev_full   = o_perf.buffer_full;
    endtask

    // Outputs sampled mid-cycle, away from both edges
    always @(negedge clk) begin
        if (!reset) begin
            assert (o_perf == '0 && !o_fetch_req && !o_dmem_valid) else begin
                failures++;
                $display("outputs not idle during reset at %0t", $time);
            end
        end else begin
            fetch_pend   = o_fetch_req;
            fetch_addr_q = o_fetch_addr;
            assert (!(o_dmem_valid && (load_pend || i_dmem_rvalid))) else begin
                failures++;
                $display("data port strobe while a load is outstanding at %0t", $time);
            end
            if (o_dmem_valid && o_dmem_req.we) begin
                ram[o_dmem_req.addr >> 2] = o_dmem_req.wdata;
                check_store(o_dmem_req.addr, o_dmem_req.wdata);
            end else if (o_dmem_valid) begin
                load_pend   = 1'b1;
                load_addr_q = o_dmem_req.addr;
                load_lat    = 1 + int'({$random(seed)} % 32'd3);
            end
            check_perf();
        end
    end

    // Responses go out 1 ns after the rising edge
    always @(posedge clk) begin
        #1;
        i_fetch_valid = fetch_pend;
        for (int k = 0; k < NUM_LANES; k++) begin
            i_fetch_words[k] = fetch_pend ? rom_word(fetch_addr_q + word_t'(4 * k)) : '0;
        end
        fetch_pend    = 1'b0;
        i_dmem_rvalid = 1'b0;
        if (load_pend) begin
            load_lat = load_lat - 1;
            if (load_lat == 0) begin
                i_dmem_rvalid = 1'b1;
                i_dmem_rdata  = ram[load_addr_q >> 2];
                load_pend     = 1'b0;
            end
        end
    end

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        int waited;
        clk           = 1'b0;
        reset         = 1'b1;
        i_fetch_valid = 1'b0;
        i_fetch_words = '0;
        i_dmem_rvalid = 1'b0;
        i_dmem_rdata  = '0;
        seed          = 32'hd86a_49d0;
        mismatches    = 0;
        failures      = 0;
        store_count   = 0;
        prog_len      = 0;
        fetch_pend    = 1'b0;
        fetch_addr_q  = '0;
        load_pend     = 1'b0;
        load_addr_q   = '0;
        load_lat      = 0;
        counting      = 1'b0;
        prev_cycles   = '0;
        prev_full     = '0;
        // Fill pattern mixes every address bit
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i]     = (word_t'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
            ref_ram[i] = ram[i];
        end
        build_program();
        run_reference();

        #1 reset = 1'b0;
        repeat (3) @(posedge clk);
        #1 reset = 1'b1;

        waited = 0;
        while (store_count < exp_addr.size() && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (store_count < exp_addr.size()) begin
            failures++;
            $display("timed out with %0d of %0d stores seen", store_count, exp_addr.size());
        end

        // Let the rest of the program retire
        waited = 0;
        while (o_perf.retired < word_t'(prog_len) && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (o_perf.retired < word_t'(prog_len)) begin
            failures++;
            $display("timed out with %0d of %0d instructions retired",
                     o_perf.retired, prog_len);
        end

        $display("%0d mismatches, %0d other errors, %0d of %0d stores, %0d retired in %0d cycles",
                 mismatches, failures, store_count, exp_addr.size(),
                 o_perf.retired, o_perf.cycles);
        if (mismatches + failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: trio_pkg.sv
package trio_pkg;

    localparam int XLEN      = 32;
    localparam int NUM_LANES = 3;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // Major opcodes the lanes execute
    // Any other opcode retires as a nop
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_t;

    // One instruction buffer slot
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_entry_t;

    // Word access on the data port
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } dmem_req_t;

    typedef struct packed {
        word_t cycles;
        word_t retired;
        word_t arb_stalls;
        word_t buffer_full;
    } perf_t;

endpackage
